// File: id_stage.f
+incdir+test
src/id_pkg.sv
src/id_stage_reg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_stage.sv
test/id_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/id_stage_cases.svh
// columns: name, ex_bus, mem_bus, wb_bus, ex_allowin, inst, pc,
//   out_valid, id_allowin, src1 sel/value, src2 sel/value, rf_we, rf_waddr,
//   taken, target, br stall, excp_en, ecode
localparam int num_cases = 25;

case_t cases [num_cases] = '{
    '{"add_w", '0, '0, '0, 1'b1, 32'h00100825, 32'h1c000000,
      1'b1, 1'b1, rg, 32'd1, rg, 32'd2, 1'b1, 5'd5, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"sub_w", '0, '0, '0, 1'b1, 32'h00111066, 32'h1c000004,
      1'b1, 1'b1, rg, 32'd3, rg, 32'd4, 1'b1, 5'd6, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"slt", '0, '0, '0, 1'b1, 32'h00122507, 32'h1c000008,
      1'b1, 1'b1, rg, 32'd8, rg, 32'd9, 1'b1, 5'd7, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"sll_w", '0, '0, '0, 1'b1, 32'h00170528, 32'h1c00000c,
      1'b1, 1'b1, rg, 32'd9, rg, 32'd1, 1'b1, 5'd8, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"bl", '0, '0, '0, 1'b1, 32'h54004000, 32'h1c000010,
      1'b1, 1'b1, lit, 32'h1c000010, lit, 32'd4, 1'b1, 5'd1,
      1'b1, 32'h1c000050, 1'b0, 1'b0, 6'h00},
    '{"addi_w", '0, '0, '0, 1'b1, 32'h02bffc49, 32'h1c000020,
      1'b1, 1'b1, rg, 32'd2, lit, 32'hffffffff, 1'b1, 5'd9, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"andi", '0, '0, '0, 1'b1, 32'h0363c069, 32'h1c000024,
      1'b1, 1'b1, rg, 32'd3, lit, 32'h000008f0, 1'b1, 5'd9, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"slli_w", '0, '0, '0, 1'b1, 32'h0040fc89, 32'h1c000028,
      1'b1, 1'b1, rg, 32'd4, lit, 32'd31, 1'b1, 5'd9, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"lu12i_w", '0, '0, '0, 1'b1, 32'h15000029, 32'h1c00002c,
      1'b1, 1'b1, skip, 32'h0, lit, 32'h80001000, 1'b1, 5'd9, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"pcaddu12i", '0, '0, '0, 1'b1, 32'h1c000069, 32'h1c000100,
      1'b1, 1'b1, lit, 32'h1c000100, lit, 32'h00003000, 1'b1, 5'd9,
      1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"fwd_ex", '{1'b1, 5'd20, 32'haaaa0001, 1'b0}, '{1'b1, 5'd20, 32'hbbbb0002, 1'b0},
      '{1'b1, 5'd20, 32'hcccc0003}, 1'b1, 32'h00105289, 32'h1c000104,
      1'b1, 1'b1, lit, 32'haaaa0001, lit, 32'haaaa0001, 1'b1, 5'd9,
      1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"fwd_mem", '0, '{1'b1, 5'd20, 32'hbbbb0004, 1'b0}, '{1'b1, 5'd20, 32'hcccc0005},
      1'b1, 32'h00105289, 32'h1c000108,
      1'b1, 1'b1, lit, 32'hbbbb0004, lit, 32'hbbbb0004, 1'b1, 5'd9,
      1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"fwd_r0", '{1'b1, 5'd0, 32'haaaa0006, 1'b0}, '{1'b1, 5'd0, 32'hbbbb0007, 1'b0},
      '{1'b1, 5'd0, 32'hcccc0008}, 1'b1, 32'h00100009, 32'h1c00010c,
      1'b1, 1'b1, lit, 32'h0, lit, 32'h0, 1'b1, 5'd9, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"ld_stall", '{1'b1, 5'd12, 32'h00000005, 1'b1}, '0, '0, 1'b1, 32'h5800214c,
      32'h1c000110, 1'b0, 1'b0, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0,
      1'b0, 32'h0, 1'b1, 1'b0, 6'h00},
    '{"bkpress", '0, '0, '0, 1'b0, 32'h00100825, 32'h1c000114,
      1'b1, 1'b0, rg, 32'd1, rg, 32'd2, 1'b1, 5'd5, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"beq_t", '0, '0, '0, 1'b1, 32'h5800214c, 32'h1c000200,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b1, 32'h1c000220, 1'b0, 1'b0, 6'h00},
    '{"bne_nt", '0, '0, '0, 1'b1, 32'h5c00214c, 32'h1c000204,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"blt_t", '0, '0, '0, 1'b1, 32'h63fff96d, 32'h1c000300,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b1, 32'h1c0002f8, 1'b0, 1'b0, 6'h00},
    '{"bgeu_t", '0, '0, '0, 1'b1, 32'h6c00216d, 32'h1c000400,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b1, 32'h1c000420, 1'b0, 1'b0, 6'h00},
    '{"b_hold", '0, '0, '0, 1'b0, 32'h50010000, 32'h1c000500,
      1'b1, 1'b0, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 1'b0, 6'h00},
    '{"b", '0, '0, '0, 1'b1, 32'h50010000, 32'h1c000500,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b1, 32'h1c000600, 1'b0, 1'b0, 6'h00},
    '{"jirl", '0, '0, '0, 1'b1, 32'h4c001141, 32'h1c000600,
      1'b1, 1'b1, lit, 32'h1c000600, lit, 32'd4, 1'b1, 5'd1,
      1'b1, 32'h00000110, 1'b0, 1'b0, 6'h00},
    '{"syscall", '0, '0, '0, 1'b1, 32'h002b0000, 32'h1c000700,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 1'b1, 6'h0b},
    '{"break", '0, '0, '0, 1'b1, 32'h002a0000, 32'h1c000704,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 1'b1, 6'h0c},
    '{"ine", '0, '0, '0, 1'b1, 32'hffffffff, 32'h1c000708,
      1'b1, 1'b1, skip, 32'h0, skip, 32'h0, 1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 1'b1, 6'h0d}
};

// File: test/id_stage_tb.sv
`timescale 1ns/1ps
module id_stage_tb;
    import id_pkg::*;

    typedef struct {
        string              name;
        stage_fwd_t         ex;
        stage_fwd_t         mem;
        wb_fwd_t            wb;
        logic               ex_allowin;
        logic [xlen-1:0]    inst;
        logic [xlen-1:0]    pc;
        logic               out_valid;
        logic               allowin;
        logic [1:0]         src1_sel;
        logic [xlen-1:0]    src1;
        logic [1:0]         src2_sel;
        logic [xlen-1:0]    src2;
        logic               we;
        logic [4:0]         waddr;
        logic               taken;
        logic [xlen-1:0]    target;
        logic               stall;
        logic               excp;
        logic [ecode_w-1:0] ecode;
    } case_t;

    localparam logic [1:0] skip = 2'd0;  // operand not checked
    localparam logic [1:0] lit  = 2'd1;
    localparam logic [1:0] rg   = 2'd2;  // expect the loaded register value

    `include "id_stage_cases.svh"

    localparam int max_cycles = num_cases * 8 + 64;

    logic       clk;
    logic       resetn;
    logic       in_valid;
    logic       ex_allowin;
    if_to_id_t  in_bus;
    stage_fwd_t ex_bus;
    stage_fwd_t mem_bus;
    wb_fwd_t    wb_bus;
    logic       id_allowin;
    logic       out_valid;
    id_to_ex_t  out_bus;
    br_bus_t    br_bus;

    logic [xlen-1:0] regval [num_regs];  // model of the register file
    logic [31:0]     lfsr;
    int              errors;
    int              checks;
    int              cycles = 0;

    id_stage id_stage_inst (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .ex_allowin (ex_allowin),
        .ex_bus     (ex_bus),
        .mem_bus    (mem_bus),
        .wb_bus     (wb_bus),
        .id_allowin (id_allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .br_bus     (br_bus)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] init_value(input int r);
        case (r)
            10:      return 32'h00000100;  // jirl base, equal to r12
            11:      return 32'hfffffffd;
            12:      return 32'h00000100;
            13:      return 32'h00000005;
            default: return random_word();
        endcase
    endfunction

    function automatic logic [xlen-1:0] operand(input logic [1:0] sel, input logic [xlen-1:0] v);
        return (sel == rg) ? regval[v[4:0]] : v;
    endfunction

    task automatic check(input string name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    task automatic load_registers();
        for (int r = 1; r < num_regs; r++) begin
            @(posedge clk);
            #1;
            regval[r] = init_value(r);
            wb_bus    = '{we: 1'b1, waddr: reg_addr_w'(r), wdata: regval[r]};
        end
        @(posedge clk);
        #1 wb_bus = '0;
    endtask

    task automatic compare_outputs(input case_t c);
        check(c.name, "out_valid", 32'(c.out_valid), 32'(out_valid));
        check(c.name, "id_allowin", 32'(c.allowin), 32'(id_allowin));
        if (c.out_valid) begin
            check(c.name, "pc", c.pc, out_bus.pc);
        end
        if (c.src1_sel != skip) begin
            check(c.name, "alu_src1", operand(c.src1_sel, c.src1), out_bus.alu_src1);
        end
        if (c.src2_sel != skip) begin
            check(c.name, "alu_src2", operand(c.src2_sel, c.src2), out_bus.alu_src2);
        end
        check(c.name, "rf_we", 32'(c.we), 32'(out_bus.rf_we));
        if (c.we) begin
            check(c.name, "rf_waddr", 32'(c.waddr), 32'(out_bus.rf_waddr));
        end
        check(c.name, "br_taken", 32'(c.taken), 32'(br_bus.taken));
        if (c.taken) begin
            check(c.name, "br_target", c.target, br_bus.target);
        end
        check(c.name, "br_stall", 32'(c.stall), 32'(br_bus.stall));
        check(c.name, "excp_en", 32'(c.excp), 32'(out_bus.excp_en));
        if (c.excp) begin
            check(c.name, "ecode", 32'(c.ecode), 32'(out_bus.ecode));
        end
    endtask

    task automatic run_case(input case_t c);
        logic accepted;
        @(posedge clk);
        #1;
        ex_bus     = c.ex;
        mem_bus    = c.mem;
        wb_bus     = c.wb;
        ex_allowin = c.ex_allowin;
        in_valid   = 1'b1;
        in_bus     = '{pc: c.pc, inst: c.inst};
        do begin
            @(negedge clk);
            accepted = id_allowin;
            @(posedge clk);
        end while (!accepted);
        #1 in_valid = c.taken;  // wrong-path fetch behind a taken branch
        @(negedge clk);
        compare_outputs(c);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (c.wb.we && c.wb.waddr != '0) begin
            regval[c.wb.waddr] = c.wb.wdata;  // wb write landed
        end
        ex_bus     = '0;
        mem_bus    = '0;
        wb_bus     = '0;
        ex_allowin = 1'b1;
        if (c.taken) begin
            @(negedge clk);
            check(c.name, "flushed", 32'h0, 32'(out_valid));
        end
        @(posedge clk);
        @(negedge clk);
        check(c.name, "drained", 32'h0, 32'(out_valid));
    endtask

    initial begin
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_bus     = '0;
        ex_allowin = 1'b1;
        ex_bus     = '0;
        mem_bus    = '0;
        wb_bus     = '0;
        lfsr       = 32'h61ca_495c;
        errors     = 0;
        checks     = 0;
        regval[0]  = '0;
        repeat (16) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check("reset", "out_valid", 32'h0, 32'(out_valid));
        check("reset", "id_allowin", 32'h1, 32'(id_allowin));
        check("reset", "br_taken", 32'h0, 32'(br_bus.taken));
        load_registers();
        for (int i = 0; i < num_cases; i++) begin
            run_case(cases[i]);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: src/id_stage.sv
`timescale 1ns/1ps
module id_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  id_pkg::if_to_id_t  in_bus,
    input  logic               ex_allowin,
    input  id_pkg::stage_fwd_t ex_bus,
    input  id_pkg::stage_fwd_t mem_bus,
    input  id_pkg::wb_fwd_t    wb_bus,
    output logic               id_allowin,
    output logic               out_valid,
    output id_pkg::id_to_ex_t  out_bus,
    output id_pkg::br_bus_t    br_bus
);
    import id_pkg::*;

    logic                  id_valid;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       pc;
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       br_offs;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    logic                  stall;
    logic                  excp;

    id_stage_reg id_stage_reg_inst (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .ex_allowin (ex_allowin),
        .stall      (stall),
        .br_taken   (br_bus.taken),
        .id_valid   (id_valid),
        .id_allowin (id_allowin),
        .out_valid  (out_valid),
        .inst       (inst),
        .pc         (pc)
    );

    inst_decoder inst_decoder_inst (
        .inst    (inst),
        .ctrl    (ctrl),
        .rd      (rd),
        .rj      (rj),
        .rk      (rk),
        .imm     (imm),
        .br_offs (br_offs)
    );

    assign raddr2 = ctrl.src2_is_rd ? rd : rk;

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (raddr2),
        .wb     (wb_bus),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_forward operand_forward_inst (
        .raddr1    (rj),
        .raddr2    (raddr2),
        .need_r1   (ctrl.need_r1),
        .need_r2   (ctrl.need_r2),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .ex_bus    (ex_bus),
        .mem_bus   (mem_bus),
        .wb_bus    (wb_bus),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit branch_unit_inst (
        .kind       (ctrl.br_kind),
        .pc         (pc),
        .br_offs    (br_offs),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .id_valid   (id_valid),
        .stall      (stall),
        .ex_allowin (ex_allowin),
        .br_bus     (br_bus)
    );

    assign excp = ctrl.excp_sys | ctrl.excp_brk | ctrl.excp_ine;

    always_comb begin
        out_bus.alu_op       = ctrl.alu_op;
        out_bus.alu_src1     = ctrl.src1_is_pc ? pc : rj_value;
        out_bus.alu_src2     = ctrl.src2_is_imm ? imm : rkd_value;
        out_bus.rkd_value    = rkd_value;
        out_bus.mem_we       = ctrl.mem_we;
        out_bus.res_from_mem = ctrl.mem_re;
        out_bus.mem_size     = ctrl.mem_size;
        out_bus.mem_unsigned = ctrl.mem_unsigned;
        out_bus.rf_we        = ctrl.gr_we & ~excp;
        out_bus.rf_waddr     = ctrl.dst_is_r1 ? reg_addr_w'(1) : rd;  // bl links to r1
        out_bus.pc           = pc;
        out_bus.excp_en      = excp;
        // break beats ine beats syscall
        if (ctrl.excp_brk) begin
            out_bus.ecode = ecode_brk;
        end else if (ctrl.excp_ine) begin
            out_bus.ecode = ecode_ine;
        end else if (ctrl.excp_sys) begin
            out_bus.ecode = ecode_sys;
        end else begin
            out_bus.ecode = '0;
        end
    end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps
module branch_unit (
    input  id_pkg::br_kind_e        kind,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] br_offs,
    input  logic [id_pkg::xlen-1:0] rj_value,
    input  logic [id_pkg::xlen-1:0] rkd_value,
    input  logic                    id_valid,
    input  logic                    stall,
    input  logic                    ex_allowin,
    output id_pkg::br_bus_t         br_bus
);
    import id_pkg::*;

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    always_comb begin
        case (kind)
            br_beq:  cond = eq;
            br_bne:  cond = ~eq;
            br_blt:  cond = lt;
            br_bge:  cond = ~lt;
            br_bltu: cond = ltu;
            br_bgeu: cond = ~ltu;
            br_b, br_bl, br_jirl: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        // hold off until operands are final and EX can take the branch
        br_bus.taken  = cond && id_valid && !stall && ex_allowin;
        br_bus.target = (kind == br_jirl) ? rj_value + br_offs : pc + br_offs;
        br_bus.stall  = id_valid && stall && kind != br_none;
    end

endmodule

// File: src/operand_forward.sv
`timescale 1ns/1ps
module operand_forward (
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    input  logic                          need_r1,
    input  logic                          need_r2,
    input  logic [id_pkg::xlen-1:0]       rdata1,
    input  logic [id_pkg::xlen-1:0]       rdata2,
    input  id_pkg::stage_fwd_t            ex_bus,
    input  id_pkg::stage_fwd_t            mem_bus,
    input  id_pkg::wb_fwd_t               wb_bus,
    output logic [id_pkg::xlen-1:0]       rj_value,
    output logic [id_pkg::xlen-1:0]       rkd_value,
    output logic                          stall
);
    import id_pkg::*;

    logic ex_hit1;
    logic ex_hit2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;

    function automatic logic fwd_hit(input logic [reg_addr_w-1:0] ra, input logic need,
                                     input logic we, input logic [reg_addr_w-1:0] wa);
        return need && we && ra != '0 && ra == wa;
    endfunction

    assign ex_hit1  = fwd_hit(raddr1, need_r1, ex_bus.we, ex_bus.waddr);
    assign ex_hit2  = fwd_hit(raddr2, need_r2, ex_bus.we, ex_bus.waddr);
    assign mem_hit1 = fwd_hit(raddr1, need_r1, mem_bus.we, mem_bus.waddr);
    assign mem_hit2 = fwd_hit(raddr2, need_r2, mem_bus.we, mem_bus.waddr);
    assign wb_hit1  = fwd_hit(raddr1, need_r1, wb_bus.we, wb_bus.waddr);
    assign wb_hit2  = fwd_hit(raddr2, need_r2, wb_bus.we, wb_bus.waddr);

    // youngest producer wins
    assign rj_value  = ex_hit1  ? ex_bus.wdata  :
                       mem_hit1 ? mem_bus.wdata :
                       wb_hit1  ? wb_bus.wdata  : rdata1;
    assign rkd_value = ex_hit2  ? ex_bus.wdata  :
                       mem_hit2 ? mem_bus.wdata :
                       wb_hit2  ? wb_bus.wdata  : rdata2;

    always_comb begin
        stall = ((ex_hit1 | ex_hit2) & ex_bus.is_load)
              | ((mem_hit1 | mem_hit2) & mem_bus.is_load);  // load data not ready yet
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps
module regfile (
    input  logic                          clk,
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    input  id_pkg::wb_fwd_t               wb,
    output logic [id_pkg::xlen-1:0]       rdata1,
    output logic [id_pkg::xlen-1:0]       rdata2
);
    import id_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ps
module inst_decoder (
    input  logic [id_pkg::xlen-1:0]       inst,
    output id_pkg::ctrl_t                 ctrl,
    output logic [id_pkg::reg_addr_w-1:0] rd,
    output logic [id_pkg::reg_addr_w-1:0] rj,
    output logic [id_pkg::reg_addr_w-1:0] rk,
    output logic [id_pkg::xlen-1:0]       imm,
    output logic [id_pkg::xlen-1:0]       br_offs
);
    import id_pkg::*;

    logic      hit;
    logic      is_3r;
    logic      is_ld;
    logic      is_st;
    logic      is_sys;
    logic      is_brk;
    logic      is_pcadd;
    logic      link;
    logic      cond_br;
    alu_op_e   alu;
    imm_kind_e imm_k;
    br_kind_e  br_k;
    mem_size_e msize;
    logic      munsigned;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    always_comb begin
        hit       = 1'b1;
        is_3r     = 1'b0;
        is_ld     = 1'b0;
        is_st     = 1'b0;
        is_sys    = 1'b0;
        is_brk    = 1'b0;
        is_pcadd  = 1'b0;
        alu       = alu_add;
        imm_k     = imm_none;
        br_k      = br_none;
        msize     = mem_word;
        munsigned = 1'b0;
        if (inst[31:20] == 12'h001) begin  // 3R alu group
            is_3r = 1'b1;
            case (inst[19:15])
                5'h00: alu = alu_add;
                5'h02: alu = alu_sub;
                5'h04: alu = alu_slt;
                5'h05: alu = alu_sltu;
                5'h08: alu = alu_nor;
                5'h09: alu = alu_and;
                5'h0a: alu = alu_or;
                5'h0b: alu = alu_xor;
                5'h0e: alu = alu_sll;
                5'h0f: alu = alu_srl;
                5'h10: alu = alu_sra;
                default: hit = 1'b0;
            endcase
        end else if (inst[31:20] == 12'h002) begin
            is_sys = inst[19:15] == 5'h16;
            is_brk = inst[19:15] == 5'h14;
            hit    = is_sys | is_brk;
        end else if (inst[31:20] == 12'h004) begin  // shift by ui5
            imm_k = imm_ui5;
            case (inst[19:15])
                5'h01: alu = alu_sll;
                5'h09: alu = alu_srl;
                5'h11: alu = alu_sra;
                default: hit = 1'b0;
            endcase
        end else if (inst[31:25] == 7'b0000001) begin
            imm_k = inst[24] ? imm_ui12 : imm_si12;  // logic ops zero extend
            case (inst[24:22])
                3'h0: alu = alu_slt;
                3'h1: alu = alu_sltu;
                3'h2: alu = alu_add;
                3'h5: alu = alu_and;
                3'h6: alu = alu_or;
                3'h7: alu = alu_xor;
                default: hit = 1'b0;
            endcase
        end else if (inst[31:25] == 7'b0001010) begin  // lu12i.w
            alu   = alu_lui;
            imm_k = imm_si20_hi;
        end else if (inst[31:25] == 7'b0001110) begin  // pcaddu12i
            is_pcadd = 1'b1;
            imm_k    = imm_si20_hi;
        end else if (inst[31:26] == 6'h0a) begin
            imm_k     = imm_si12;
            is_st     = inst[24];
            is_ld     = ~inst[24];
            munsigned = inst[25];
            case (inst[23:22])
                2'b00: msize = mem_byte;
                2'b01: msize = mem_half;
                2'b10: msize = mem_word;
                default: hit = 1'b0;
            endcase
            if (inst[25] && (inst[24] || inst[23])) begin
                hit = 1'b0;  // only ld.bu and ld.hu are unsigned
            end
        end else begin
            case (inst[31:26])
                6'h13: br_k = br_jirl;
                6'h14: br_k = br_b;
                6'h15: br_k = br_bl;
                6'h16: br_k = br_beq;
                6'h17: br_k = br_bne;
                6'h18: br_k = br_blt;
                6'h19: br_k = br_bge;
                6'h1a: br_k = br_bltu;
                6'h1b: br_k = br_bgeu;
                default: hit = 1'b0;
            endcase
        end
    end

    assign link    = br_k == br_bl || br_k == br_jirl;
    assign cond_br = br_k inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

    always_comb begin
        ctrl              = '0;
        ctrl.alu_op       = alu;
        ctrl.br_kind      = br_k;
        ctrl.imm_kind     = link ? imm_four : imm_k;  // link value is pc + 4
        ctrl.src1_is_pc   = link || is_pcadd;
        ctrl.src2_is_imm  = ctrl.imm_kind != imm_none;
        ctrl.src2_is_rd   = is_st || cond_br;
        ctrl.need_r1      = hit && (is_3r || cond_br || br_k == br_jirl
                                    || imm_k inside {imm_si12, imm_ui12, imm_ui5});
        ctrl.need_r2      = hit && (is_3r || is_st || cond_br);
        ctrl.gr_we        = hit && !(is_st || cond_br || br_k == br_b);
        ctrl.dst_is_r1    = br_k == br_bl;
        ctrl.mem_re       = hit && is_ld;
        ctrl.mem_we       = hit && is_st;
        ctrl.mem_size     = msize;
        ctrl.mem_unsigned = munsigned;
        ctrl.excp_sys     = is_sys;
        ctrl.excp_brk     = is_brk;
        ctrl.excp_ine     = !hit;
    end

    always_comb begin
        case (ctrl.imm_kind)
            imm_si12:    imm = {{(xlen-12){inst[21]}}, inst[21:10]};
            imm_ui12:    imm = {{(xlen-12){1'b0}}, inst[21:10]};
            imm_ui5:     imm = {{(xlen-5){1'b0}}, inst[14:10]};
            imm_si20_hi: imm = {inst[24:5], 12'b0};
            imm_four:    imm = xlen'(4);
            default:     imm = '0;
        endcase
    end

    // b and bl carry offs26, the rest offs16
    assign br_offs = (br_k == br_b || br_k == br_bl) ?
                     {{(xlen-28){inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                     {{(xlen-18){inst[25]}}, inst[25:10], 2'b0};

endmodule

// File: src/id_stage_reg.sv
`timescale 1ns/1ps
module id_stage_reg (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    input  id_pkg::if_to_id_t       in_bus,
    input  logic                    ex_allowin,
    input  logic                    stall,
    input  logic                    br_taken,
    output logic                    id_valid,
    output logic                    id_allowin,
    output logic                    out_valid,
    output logic [id_pkg::xlen-1:0] inst,
    output logic [id_pkg::xlen-1:0] pc
);
    logic ready_go;

    assign ready_go   = ~stall;
    assign out_valid  = id_valid & ready_go;
    // taken branch also frees the slot so the wrong-path fetch is dropped
    assign id_allowin = ~id_valid | (ready_go & ex_allowin) | br_taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && id_allowin) begin
            inst <= in_bus.inst;
            pc   <= in_bus.pc;
        end
    end

    held_under_backpressure: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid && !ex_allowin |=> $stable(inst) && $stable(pc)
    );

endmodule

// File: src/id_pkg.sv
package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int ecode_w    = 6;

    localparam logic [ecode_w-1:0] ecode_sys = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine = 6'h0d;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_b, br_bl, br_jirl
    } br_kind_e;

    typedef enum logic [1:0] {
        mem_byte, mem_half, mem_word
    } mem_size_e;

    typedef enum logic [2:0] {
        imm_none, imm_si12, imm_ui12, imm_ui5, imm_si20_hi, imm_four
    } imm_kind_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } if_to_id_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } wb_fwd_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
        logic                  is_load;  // result still waits on memory
    } stage_fwd_t;

    typedef struct packed {
        alu_op_e   alu_op;
        br_kind_e  br_kind;
        imm_kind_e imm_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_rd;   // stores and compare branches read rd
        logic      need_r1;
        logic      need_r2;
        logic      gr_we;
        logic      dst_is_r1;
        logic      mem_re;
        logic      mem_we;
        mem_size_e mem_size;
        logic      mem_unsigned;
        logic      excp_sys;
        logic      excp_brk;
        logic      excp_ine;
    } ctrl_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
        logic            stall;
    } br_bus_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [xlen-1:0]       alu_src1;
        logic [xlen-1:0]       alu_src2;
        logic [xlen-1:0]       rkd_value;   // store data
        logic                  mem_we;
        logic                  res_from_mem;
        mem_size_e             mem_size;
        logic                  mem_unsigned;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       pc;
        logic                  excp_en;
        logic [ecode_w-1:0]    ecode;
    } id_to_ex_t;

endpackage
